//--- bar_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module bar_pattern_gen import video_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic [1:0]  pattern_sel,
    input  logic        next_pixel,
    input  logic        start_of_line,
    input  logic [8:0]  display_line_idx,

    output logic [11:0] palette_rgb_data
);

    logic [10:0] pix_cnt;
    logic [1:0]  pattern;
    logic [2:0]  bar_idx;
    logic [3:0]  ramp_lvl;
    logic [11:0] pattern_rgb;

    // pixel position within the active line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_cnt <= 11'd0;
        end else if (start_of_line) begin
            pix_cnt <= 11'd0;
        end else if (next_pixel) begin
            pix_cnt <= pix_cnt + 11'd1;
        end
    end

    // pattern only changes on a line boundary
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern <= PAT_BARS;
        end else if (start_of_line) begin
            pattern <= pattern_sel;
        end
    end

    assign bar_idx  = 3'(pix_cnt / BAR_WIDTH);
    assign ramp_lvl = 4'(pix_cnt / RAMP_WIDTH);

    always_comb begin
        case (pattern)
            PAT_BARS:  pattern_rgb = BAR_PALETTE[bar_idx];
            PAT_RAMP:  pattern_rgb = {ramp_lvl, ramp_lvl, ramp_lvl};
            PAT_SOLID: pattern_rgb = SOLID_COLOR;
            // even lines white, odd lines black
            PAT_LINES: pattern_rgb = display_line_idx[0] ? RGB_BLACK : RGB_WHITE;
            default:   pattern_rgb = RGB_BLACK;
        endcase
    end

    // blank outside the active window
    assign palette_rgb_data = next_pixel ? pattern_rgb : RGB_BLACK;

endmodule

`default_nettype wire

//--- tb.f
video_pkg.sv
video_modulator.sv
bar_pattern_gen.sv
video_composite.sv
video_top.sv
video_top_assert.sv
tb_video_top.sv

//--- tb_video_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_top import video_pkg::*;;

    localparam int RESET_CYCLES   = 8;
    localparam int FRAME_CYCLES   = int'(V_TOTAL) * int'(H_HALF);
    // 1.1 frames of raster plus the reset
    localparam int TIMEOUT_CYCLES = FRAME_CYCLES + FRAME_CYCLES / 10 + RESET_CYCLES;
    localparam int PIX_START      = int'(H_SYNC) + int'(H_BACK_PORCH);
    localparam int PIX_END        = PIX_START + int'(H_ACTIVE);

    typedef struct packed {
        logic [1:0]  pat;
        logic [9:0]  line;
        logic [10:0] col;
        logic [11:0] rgb;
        logic [4:0]  luma;
        logic        chroma_off;
        logic [3:0]  hue;
    } row_t;

    logic       clk;
    logic       rst;
    logic [1:0] pattern_sel;
    logic [4:0] luma;
    logic       sync_n;
    logic [3:0] chroma;
    logic [3:0] rgb_r;
    logic [3:0] rgb_g;
    logic [3:0] rgb_b;
    logic       rgb_sync_n;
    logic       start_of_screen;
    logic       end_of_screen;
    logic [8:0] display_line_idx;

    // reference raster, m_t counts clocks since reset release
    int   m_h;
    int   m_v;
    int   m_t;
    int   m_line;
    logic m_field;
    logic running;
    logic prev_sync;
    logic exp_sync;
    logic exp_sos;
    logic exp_eos;
    logic [8:0] exp_idx;
    logic [3:0] exp_burst;

    int     errors;
    int     checks;
    int     cycles;
    int     assert_fails;
    integer seed;
    row_t   rows [$];

    video_top i_dut (
        .clk              (clk),
        .rst              (rst),
        .pattern_sel      (pattern_sel),
        .luma             (luma),
        .sync_n           (sync_n),
        .chroma           (chroma),
        .rgb_r            (rgb_r),
        .rgb_g            (rgb_g),
        .rgb_b            (rgb_b),
        .rgb_sync_n       (rgb_sync_n),
        .start_of_screen  (start_of_screen),
        .end_of_screen    (end_of_screen),
        .display_line_idx (display_line_idx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: raster did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    function automatic logic in_active(input int v);
        return (v >= V_ACTIVE_F0_FIRST && v <= V_ACTIVE_F0_LAST) ||
               (v >= V_ACTIVE_F1_FIRST && v <= V_ACTIVE_F1_LAST);
    endfunction

    // pulse shape by half-line class
    function automatic logic sync_low(input int v, input int h);
        int hh;
        hh = (h >= int'(H_HALF)) ? h - int'(H_HALF) : h;
        if ((v >= V_SYNC_F0_FIRST && v <= V_SYNC_F0_LAST) ||
            (v >= V_SYNC_F1_FIRST && v <= V_SYNC_F1_LAST)) begin
            return hh < int'(H_VSYNC_PULSE_LEN);
        end
        if ((v >= V_EQ1_F0_FIRST && v <= V_EQ2_F0_LAST) ||
            (v >= V_EQ1_F1_FIRST && v <= V_EQ2_F1_LAST)) begin
            return hh < int'(H_EQ_PULSE_LEN);
        end
        return h < int'(H_SYNC);
    endfunction

    task automatic advance_model();
        if (m_h == int'(H_HALF) - 1 || m_h == int'(H_TOTAL) - 1) begin
            // field bit cleared at the frame wrap, set after half-line 524
            if (m_v == int'(V_TOTAL) - 1) begin
                m_field = 1'b0;
                m_line  = 0;
            end else if (m_v == int'(V_FIELD_LAST)) begin
                m_field = 1'b1;
                m_line  = 0;
            end else if (m_h == int'(H_TOTAL) - 1) begin
                m_line = m_line + 1;
            end
            m_v = (m_v == int'(V_TOTAL) - 1) ? 0 : m_v + 1;
        end
        m_h = (m_h == int'(H_TOTAL) - 1) ? 0 : m_h + 1;
        m_t = m_t + 1;
    endtask

    // per-clock checks at the falling edge, then step the model
    always @(negedge clk) begin
        if (running) begin
            exp_sync  = !sync_low(m_v, m_h);
            exp_sos   = (m_h == int'(H_TOTAL) - 1) && (m_v == int'(V_ACTIVE_F0_FIRST) - 1 ||
                                                       m_v == int'(V_ACTIVE_F1_FIRST) - 1);
            // last clock of the closing half-line of each field
            exp_eos   = (m_h == int'(H_HALF) - 1 || m_h == int'(H_TOTAL) - 1) &&
                        (m_v == int'(V_FIELD_LAST) || m_v == int'(V_TOTAL) - 1);
            exp_idx   = 9'(2 * m_line + int'(m_field));
            exp_burst = in_active(m_v) ? 4'(m_t - 1 + int'(BURST_PHASE)) : 4'd0;
            check_val("rgb_sync_n", exp_sync, rgb_sync_n);
            check_val("sync_n", prev_sync, sync_n);
            check_val("start_of_screen", exp_sos, start_of_screen);
            check_val("end_of_screen", exp_eos, end_of_screen);
            check_val("display_line_idx", exp_idx, display_line_idx);
            if (m_h < PIX_START || m_h >= PIX_END) begin
                check_val("rgb", 0, {rgb_r, rgb_g, rgb_b});
            end
            // burst appears on chroma one clock after its window
            if (m_h > int'(H_BURST_START) && m_h <= int'(H_BURST_END)) begin
                check_val("chroma", exp_burst, chroma);
            end
            prev_sync = exp_sync;
            advance_model();
        end
    end

    task automatic wait_for_position(input int v, input int h);
        do begin
            @(posedge clk);
            #1;
        end while (m_v != v || m_h != h);
    endtask

    task automatic apply_row(input row_t row);
        int         col;
        int         h;
        int         t;
        logic [3:0] exp_chroma;
        col = int'(row.col) + int'($unsigned($random(seed)) % 80);
        h   = PIX_START + col;
        // select the pattern in the second half of the line before
        wait_for_position(2 * row.line - 1, int'(H_HALF));
        pattern_sel = row.pat;
        wait_for_position(2 * row.line + ((h >= int'(H_HALF)) ? 1 : 0), h);
        t = m_t;
        check_val("rgb", row.rgb, {rgb_r, rgb_g, rgb_b});
        @(posedge clk);
        #1;
        exp_chroma = row.chroma_off ? 4'd0 : 4'(t + int'(row.hue));
        check_val("luma", row.luma, luma);
        check_val("chroma", exp_chroma, chroma);
    endtask

    initial begin
        rst         = 1'b1;
        pattern_sel = PAT_BARS;
        running     = 1'b0;
        m_h         = 0;
        m_v         = 0;
        m_t         = 0;
        m_line      = 0;
        m_field     = 1'b0;
        prev_sync   = 1'b0;
        errors      = 0;
        checks      = 0;
        seed        = 32'h52cd;

        // pattern, line, first column, rgb, luma, no chroma, hue
        rows.push_back(row_t'{PAT_BARS,  10'd5,   11'd0,    12'hFFF, 5'd0,  1'b1, 4'h0});
        rows.push_back(row_t'{PAT_BARS,  10'd30,  11'd160,  12'hFF0, 5'd22, 1'b0, 4'h3});
        rows.push_back(row_t'{PAT_BARS,  10'd40,  11'd320,  12'h0FF, 5'd22, 1'b0, 4'hC});
        rows.push_back(row_t'{PAT_BARS,  10'd50,  11'd480,  12'h0F0, 5'd15, 1'b0, 4'h0});
        rows.push_back(row_t'{PAT_BARS,  10'd60,  11'd640,  12'hF0F, 5'd15, 1'b0, 4'hF});
        rows.push_back(row_t'{PAT_BARS,  10'd70,  11'd800,  12'hF00, 5'd7,  1'b0, 4'h3});
        rows.push_back(row_t'{PAT_BARS,  10'd80,  11'd960,  12'h00F, 5'd7,  1'b0, 4'hC});
        rows.push_back(row_t'{PAT_BARS,  10'd90,  11'd1120, 12'h000, 5'd0,  1'b1, 4'h0});
        rows.push_back(row_t'{PAT_RAMP,  10'd130, 11'd400,  12'h555, 5'd10, 1'b1, 4'h0});
        rows.push_back(row_t'{PAT_RAMP,  10'd150, 11'd1200, 12'hFFF, 5'd30, 1'b1, 4'h0});
        rows.push_back(row_t'{PAT_SOLID, 10'd200, 11'd80,   12'h48C, 5'd16, 1'b0, 4'hD});
        // line 240 lies in field 0, so its index is even
        rows.push_back(row_t'{PAT_LINES, 10'd240, 11'd640,  12'hFFF, 5'd30, 1'b1, 4'h0});
        rows.push_back(row_t'{PAT_SOLID, 10'd270, 11'd0,    12'h48C, 5'd0,  1'b1, 4'h0});
        rows.push_back(row_t'{PAT_BARS,  10'd300, 11'd240,  12'hFF0, 5'd22, 1'b0, 4'h3});
        rows.push_back(row_t'{PAT_RAMP,  10'd400, 11'd880,  12'hBBB, 5'd22, 1'b1, 4'h0});
        rows.push_back(row_t'{PAT_SOLID, 10'd500, 11'd1040, 12'h48C, 5'd16, 1'b0, 4'hD});

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst     = 1'b0;
        running = 1'b1;

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        // through the frame wrap into the next vertical interval
        wait_for_position(20, 0);

        assert_fails = i_dut.i_composite.i_assert.fail_cnt;
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- video_composite.sv
`timescale 1ns/1ps
`default_nettype none

module video_composite import video_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // pixel source
    input  logic [11:0] palette_rgb_data,
    output logic        next_pixel,

    output logic [8:0]  display_line_idx,
    output logic        start_of_screen,
    output logic        end_of_screen,
    output logic        start_of_line,

    // composite out
    output logic [4:0]  luma,
    output logic        sync_n,
    output logic [3:0]  chroma,

    // rgb out
    output logic [3:0]  rgb_r,
    output logic [3:0]  rgb_g,
    output logic [3:0]  rgb_b,
    output logic        rgb_sync_n
);

    logic [10:0] hcnt;
    logic [10:0] vcnt;
    logic        field;
    logic [8:0]  field_line_cnt;

    logic h_hsync_pulse;
    logic h_vsync_pulse;
    logic h_eq_pulse;
    logic h_burst;
    logic h_active;
    logic h_last;
    logic h_half_last;

    logic v_sync;
    logic v_eq;
    logic v_active;
    logic v_last;
    logic v_field_last;
    logic v_pre_active;

    logic       mod_sync_n;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    // horizontal shapes
    assign h_hsync_pulse = hcnt < H_SYNC;

    // serration and eq pulses repeat every half line
    assign h_vsync_pulse = (hcnt < H_VSYNC_PULSE_LEN) ||
                           (hcnt >= H_HALF && hcnt < H_HALF + H_VSYNC_PULSE_LEN);
    assign h_eq_pulse    = (hcnt < H_EQ_PULSE_LEN) ||
                           (hcnt >= H_HALF && hcnt < H_HALF + H_EQ_PULSE_LEN);

    assign h_burst     = (hcnt >= H_BURST_START) && (hcnt < H_BURST_END);
    assign h_active    = (hcnt >= H_SYNC + H_BACK_PORCH) &&
                         (hcnt < H_SYNC + H_BACK_PORCH + H_ACTIVE);
    assign h_last      = hcnt == H_TOTAL - 11'd1;
    assign h_half_last = (hcnt == H_HALF - 11'd1) || h_last;

    // vertical classes per half-line
    assign v_sync = (vcnt >= V_SYNC_F0_FIRST && vcnt <= V_SYNC_F0_LAST) ||
                    (vcnt >= V_SYNC_F1_FIRST && vcnt <= V_SYNC_F1_LAST);

    assign v_eq = (vcnt >= V_EQ1_F0_FIRST && vcnt <= V_EQ1_F0_LAST) ||
                  (vcnt >= V_EQ2_F0_FIRST && vcnt <= V_EQ2_F0_LAST) ||
                  (vcnt >= V_EQ1_F1_FIRST && vcnt <= V_EQ1_F1_LAST) ||
                  (vcnt >= V_EQ2_F1_FIRST && vcnt <= V_EQ2_F1_LAST);

    assign v_active = (vcnt >= V_ACTIVE_F0_FIRST && vcnt <= V_ACTIVE_F0_LAST) ||
                      (vcnt >= V_ACTIVE_F1_FIRST && vcnt <= V_ACTIVE_F1_LAST);

    assign v_last       = vcnt == V_TOTAL - 11'd1;
    assign v_field_last = vcnt == V_FIELD_LAST;
    // half-line just before the first visible one of each field
    assign v_pre_active = (vcnt == V_ACTIVE_F0_FIRST - 11'd1) ||
                          (vcnt == V_ACTIVE_F1_FIRST - 11'd1);

    // line and frame strobes
    assign start_of_line   = h_last;
    assign start_of_screen = h_last && v_pre_active;
    assign end_of_screen   = h_half_last && (v_field_last || v_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= 11'd0;
            vcnt <= 11'd0;
        end else begin
            hcnt <= h_last ? 11'd0 : hcnt + 11'd1;
            if (h_half_last) begin
                vcnt <= v_last ? 11'd0 : vcnt + 11'd1;
            end
        end
    end

    // field bit flips at the end of each field, line count restarts with it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            field          <= 1'b0;
            field_line_cnt <= 9'd0;
        end else if (h_half_last && v_last) begin
            field          <= 1'b0;
            field_line_cnt <= 9'd0;
        end else if (h_half_last && v_field_last) begin
            field          <= 1'b1;
            field_line_cnt <= 9'd0;
        end else if (h_last) begin
            field_line_cnt <= field_line_cnt + 9'd1;
        end
    end

    // interleave both fields into one progressive index, wraps at 512
    assign display_line_idx = {field_line_cnt[7:0], field};

    always_comb begin
        if (v_sync) begin
            mod_sync_n = !h_vsync_pulse;
        end else if (v_eq) begin
            mod_sync_n = !h_eq_pulse;
        end else begin
            mod_sync_n = !h_hsync_pulse;
        end
    end

    assign next_pixel = h_active;

    assign r = palette_rgb_data[11:8];
    assign g = palette_rgb_data[7:4];
    assign b = palette_rgb_data[3:0];

    video_modulator i_modulator (
        .clk         (clk),
        .rst         (rst),
        .r           (r),
        .g           (g),
        .b           (b),
        .color_burst (v_active && h_burst),
        .active      (v_active && h_active),
        .sync_n_in   (mod_sync_n),
        .luma        (luma),
        .sync_n      (sync_n),
        .chroma      (chroma)
    );

    assign rgb_r      = r;
    assign rgb_g      = g;
    assign rgb_b      = b;
    assign rgb_sync_n = mod_sync_n;

endmodule

`default_nettype wire

//--- video_modulator.sv
`timescale 1ns/1ps
`default_nettype none

module video_modulator import video_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic [3:0] r,
    input  logic [3:0] g,
    input  logic [3:0] b,
    input  logic       color_burst,
    input  logic       active,
    input  logic       sync_n_in,

    output logic [4:0] luma,
    output logic       sync_n,
    output logic [3:0] chroma
);

    logic [3:0] phase;
    logic [5:0] luma_sum;
    logic [3:0] hue;
    logic       gray;
    logic [4:0] luma_next;
    logic [3:0] chroma_next;

    // subcarrier phase, free running
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= 4'd0;
        end else begin
            phase <= phase + 4'd1;
        end
    end

    // green weighted twice, max sum 60
    assign luma_sum = {2'b00, r} + {1'b0, g, 1'b0} + {2'b00, b};

    // hue from blue and red msbs
    assign hue  = {b[3:2], r[3:2]};
    assign gray = (r == g) && (g == b);

    always_comb begin
        luma_next = active ? luma_sum[5:1] : 5'd0;

        if (color_burst) begin
            chroma_next = phase + BURST_PHASE;
        end else if (active && !gray) begin
            chroma_next = phase + hue;
        end else begin
            chroma_next = 4'd0;
        end
    end

    // sync starts low so the reset eq pulse is not split
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            luma   <= 5'd0;
            chroma <= 4'd0;
            sync_n <= 1'b0;
        end else begin
            luma   <= luma_next;
            chroma <= chroma_next;
            sync_n <= sync_n_in;
        end
    end

endmodule

`default_nettype wire

//--- video_pkg.sv
`default_nettype none

package video_pkg;

    // horizontal segments in pixel clocks
    localparam logic [10:0] H_SYNC        = 11'd118;
    localparam logic [10:0] H_BACK_PORCH  = 11'd152;
    localparam logic [10:0] H_ACTIVE      = 11'd1280;
    localparam logic [10:0] H_FRONT_PORCH = 11'd38;
    localparam logic [10:0] H_TOTAL       = H_SYNC + H_BACK_PORCH + H_ACTIVE + H_FRONT_PORCH;

    // half-line based pulses for the vertical interval
    localparam logic [10:0] H_HALF            = H_TOTAL / 11'd2;
    localparam logic [10:0] H_VSYNC_PULSE_LEN = 11'd678;
    localparam logic [10:0] H_EQ_PULSE_LEN    = 11'd58;

    // colour burst window on the back porch
    localparam logic [10:0] H_BURST_START = 11'd132;
    localparam logic [10:0] H_BURST_END   = 11'd196;

    // vertical timing counted in half-lines
    localparam logic [10:0] V_TOTAL      = 11'd1050;
    localparam logic [10:0] V_FIELD_LAST = 11'd524;

    // field 0 vertical interval
    localparam logic [10:0] V_EQ1_F0_FIRST  = 11'd0;
    localparam logic [10:0] V_EQ1_F0_LAST   = 11'd5;
    localparam logic [10:0] V_SYNC_F0_FIRST = 11'd6;
    localparam logic [10:0] V_SYNC_F0_LAST  = 11'd11;
    localparam logic [10:0] V_EQ2_F0_FIRST  = 11'd12;
    localparam logic [10:0] V_EQ2_F0_LAST   = 11'd17;

    // field 1 vertical interval
    localparam logic [10:0] V_EQ1_F1_FIRST  = 11'd525;
    localparam logic [10:0] V_EQ1_F1_LAST   = 11'd530;
    localparam logic [10:0] V_SYNC_F1_FIRST = 11'd531;
    localparam logic [10:0] V_SYNC_F1_LAST  = 11'd536;
    localparam logic [10:0] V_EQ2_F1_FIRST  = 11'd537;
    localparam logic [10:0] V_EQ2_F1_LAST   = 11'd542;

    // 240 visible lines per field
    localparam logic [10:0] V_ACTIVE_F0_FIRST = 11'd42;
    localparam logic [10:0] V_ACTIVE_F0_LAST  = 11'd521;
    localparam logic [10:0] V_ACTIVE_F1_FIRST = 11'd568;
    localparam logic [10:0] V_ACTIVE_F1_LAST  = 11'd1047;

    // test pattern codes
    localparam logic [1:0] PAT_BARS  = 2'd0;
    localparam logic [1:0] PAT_RAMP  = 2'd1;
    localparam logic [1:0] PAT_SOLID = 2'd2;
    localparam logic [1:0] PAT_LINES = 2'd3;

    // 12-bit rgb, red in the top nibble
    localparam logic [11:0] RGB_WHITE   = 12'hFFF;
    localparam logic [11:0] RGB_BLACK   = 12'h000;
    localparam logic [11:0] SOLID_COLOR = 12'h48C;

    localparam logic [11:0] BAR_PALETTE [8] = '{
        RGB_WHITE,
        12'hFF0,
        12'h0FF,
        12'h0F0,
        12'hF0F,
        12'hF00,
        12'h00F,
        RGB_BLACK
    };

    localparam logic [10:0] BAR_WIDTH  = 11'd160;
    // 16 gray steps across the active line
    localparam logic [10:0] RAMP_WIDTH = 11'd80;

    // chroma phase code sent during burst
    localparam logic [3:0] BURST_PHASE = 4'h8;

endpackage

`default_nettype wire

//--- video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] pattern_sel,

    // composite
    output logic [4:0] luma,
    output logic       sync_n,
    output logic [3:0] chroma,

    // rgb
    output logic [3:0] rgb_r,
    output logic [3:0] rgb_g,
    output logic [3:0] rgb_b,
    output logic       rgb_sync_n,

    output logic       start_of_screen,
    output logic       end_of_screen,
    output logic [8:0] display_line_idx
);

    logic [11:0] palette_rgb_data;
    logic        next_pixel;
    logic        start_of_line;

    // stands in for the line buffer and palette
    bar_pattern_gen i_pattern (
        .clk              (clk),
        .rst              (rst),
        .pattern_sel      (pattern_sel),
        .next_pixel       (next_pixel),
        .start_of_line    (start_of_line),
        .display_line_idx (display_line_idx),
        .palette_rgb_data (palette_rgb_data)
    );

    video_composite i_composite (
        .clk              (clk),
        .rst              (rst),
        .palette_rgb_data (palette_rgb_data),
        .next_pixel       (next_pixel),
        .display_line_idx (display_line_idx),
        .start_of_screen  (start_of_screen),
        .end_of_screen    (end_of_screen),
        .start_of_line    (start_of_line),
        .luma             (luma),
        .sync_n           (sync_n),
        .chroma           (chroma),
        .rgb_r            (rgb_r),
        .rgb_g            (rgb_g),
        .rgb_b            (rgb_b),
        .rgb_sync_n       (rgb_sync_n)
    );

endmodule

`default_nettype wire

//--- video_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module video_top_assert import video_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic sync_n,
    input  logic start_of_screen,
    input  logic end_of_screen,
    input  logic next_pixel,
    input  logic rgb_sync_n,
    input  logic vert_interval
);

    logic [11:0] low_cnt;

    // failures seen by the properties below
    int fail_cnt = 0;

    // consecutive low clocks on the composite sync
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            low_cnt <= 12'd0;
        end else if (!sync_n) begin
            low_cnt <= low_cnt + 12'd1;
        end else begin
            low_cnt <= 12'd0;
        end
    end

    sync_width: assert property (@(posedge clk) disable iff (rst)
        low_cnt <= 12'(H_VSYNC_PULSE_LEN))
        else begin
            $error("sync_n held low longer than a vsync serration pulse");
            fail_cnt = fail_cnt + 1;
        end

    strobe_excl: assert property (@(posedge clk) disable iff (rst)
        !(start_of_screen && end_of_screen))
        else begin
            $error("start_of_screen and end_of_screen high in the same clock");
            fail_cnt = fail_cnt + 1;
        end

    // serration and eq pulses reach into the active window, so normal lines only
    pixel_in_sync: assert property (@(posedge clk) disable iff (rst)
        !vert_interval |-> !(next_pixel && !rgb_sync_n))
        else begin
            $error("next_pixel high during a horizontal sync pulse");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind video_composite video_top_assert i_assert (
    .clk             (clk),
    .rst             (rst),
    .sync_n          (sync_n),
    .start_of_screen (start_of_screen),
    .end_of_screen   (end_of_screen),
    .next_pixel      (next_pixel),
    .rgb_sync_n      (rgb_sync_n),
    .vert_interval   (v_sync || v_eq)
);

`default_nettype wire
